//--- request_arbiter.sv
// request_arbiter: two-way pick between request entries by valid, boost, priority and wait

module request_arbiter #(
    parameter  int num_slots = 4,
    localparam int idx_w     = $clog2(num_slots)
) (
    input  zone_queue_pkg::request_t a,
    input  logic [idx_w-1:0]         a_index,
    input  zone_queue_pkg::request_t b,
    input  logic [idx_w-1:0]         b_index,
    output zone_queue_pkg::request_t win,
    output logic [idx_w-1:0]         win_index
);

    logic a_better;
    logic a_wins;

    // Ranking when both sides hold a request
    always_comb begin
        if (a.boost != b.boost) begin
            a_better = a.boost;
        end else if (a.prio != b.prio) begin
            a_better = (a.prio > b.prio);
        end else begin
            // Older request first, a keeps a full tie
            a_better = (a.wait_count >= b.wait_count);
        end
    end

    // Empty b always loses, empty a never wins against a full b
    assign a_wins = !b.valid || (a.valid && a_better);

    assign win       = a_wins ? a : b;
    assign win_index = a_wins ? a_index : b_index;

endmodule

//--- request_slot.sv
// request_slot: single queue entry with load, clear, saturating aging and sticky boost

module request_slot (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  zone_queue_pkg::zone_t    new_zone,
    input  zone_queue_pkg::prio_t    new_prio,
    input  logic                     clear,
    input  zone_queue_pkg::wait_t    threshold,
    output zone_queue_pkg::request_t entry
);
    import zone_queue_pkg::*;

    logic  valid_q;
    logic  boost_q;
    zone_t zone_q;
    prio_t prio_q;
    wait_t count_q;
    logic  aging;

    // A held request that is neither replaced nor removed this cycle
    assign aging = valid_q && !load && !clear;

    // ----------------------------------------
    // Occupancy and boost flags
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            boost_q <= 1'b0;
        end else if (clear) begin
            valid_q <= 1'b0;
            boost_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
            boost_q <= 1'b0;
        end else if (aging && (count_q >= threshold)) begin
            // Sticky until the slot is cleared
            boost_q <= 1'b1;
        end
    end

    // ----------------------------------------
    // Request payload and waiting count
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (load && !clear) begin
            zone_q  <= new_zone;
            prio_q  <= new_prio;
            count_q <= '0;
        end else if (aging && (count_q != '1)) begin
            count_q <= count_q + 1'b1;   // stops at all ones
        end
    end

    always_comb begin
        entry.valid      = valid_q;
        entry.boost      = boost_q;
        entry.zone       = zone_q;
        entry.prio       = prio_q;
        entry.wait_count = count_q;
    end

endmodule

//--- request_table.sv
// request_table: slot array with lowest-free allocation, serve and cancel decode, full flag

module request_table #(
    parameter  int num_slots = 4,
    localparam int idx_w     = $clog2(num_slots)
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     insert,
    input  zone_queue_pkg::zone_t                    new_zone,
    input  zone_queue_pkg::prio_t                    new_prio,
    input  logic                                     serve,
    input  logic                                     cancel,
    input  zone_queue_pkg::zone_t                    cancel_zone,
    input  zone_queue_pkg::wait_t                    threshold,
    input  logic [idx_w-1:0]                         win_index,
    output zone_queue_pkg::request_t [num_slots-1:0] slots,
    output logic                                     queue_full
);

    logic [num_slots-1:0] occupied;
    logic [num_slots-1:0] free;
    logic [num_slots-1:0] load;
    logic [num_slots-1:0] clear;

    // ----------------------------------------
    // Allocation
    // ----------------------------------------
    assign free = ~occupied;

    // Two's complement trick isolates the lowest free slot
    assign load = insert ? (free & (~free + 1'b1)) : '0;

    assign queue_full = &occupied;

    // ----------------------------------------
    // Slots with their clear decode
    // ----------------------------------------
    for (genvar i = 0; i < num_slots; i++) begin : g_slot
        assign occupied[i] = slots[i].valid;

        // Only occupied slots clear, so a clear never lands on the load target
        assign clear[i] = slots[i].valid &&
                          ((serve && (win_index == idx_w'(i))) ||
                           (cancel && (slots[i].zone == cancel_zone)));

        request_slot u_slot (
            .clk       (clk),
            .rst_n     (rst_n),
            .load      (load[i]),
            .new_zone  (new_zone),
            .new_prio  (new_prio),
            .clear     (clear[i]),
            .threshold (threshold),
            .entry     (slots[i])
        );
    end

endmodule

//--- winner_tree.sv
// winner_tree: binary tree of request arbiters reducing all slots to one winner and its index

module winner_tree #(
    parameter  int num_slots = 4,
    localparam int idx_w     = $clog2(num_slots)
) (
    input  zone_queue_pkg::request_t [num_slots-1:0] slots,
    output zone_queue_pkg::request_t                 best,
    output logic [idx_w-1:0]                         win_index
);
    import zone_queue_pkg::*;

    // Heap layout: node n has children 2n+1 and 2n+2, leaves start at num_slots-1
    request_t         node_req [2*num_slots-1];
    logic [idx_w-1:0] node_idx [2*num_slots-1];

    // ----------------------------------------
    // Leaves carry the slot numbers
    // ----------------------------------------
    for (genvar s = 0; s < num_slots; s++) begin : g_leaf
        assign node_req[num_slots-1+s] = slots[s];
        assign node_idx[num_slots-1+s] = idx_w'(s);
    end

    // ----------------------------------------
    // One arbiter level per index bit
    // ----------------------------------------
    for (genvar lvl = 0; lvl < idx_w; lvl++) begin : g_level
        for (genvar n = 0; n < 2**lvl; n++) begin : g_node
            localparam int node = 2**lvl - 1 + n;

            // Lower slots sit on the a side, so they keep full ties
            request_arbiter #(
                .num_slots (num_slots)
            ) u_arb (
                .a         (node_req[2*node+1]),
                .a_index   (node_idx[2*node+1]),
                .b         (node_req[2*node+2]),
                .b_index   (node_idx[2*node+2]),
                .win       (node_req[node]),
                .win_index (node_idx[node])
            );
        end
    end

    assign best      = node_req[0];
    assign win_index = node_idx[0];

endmodule

//--- zone_queue.f
zone_queue_pkg.sv
request_slot.sv
request_arbiter.sv
winner_tree.sv
request_table.sv
zone_queue.sv
zone_queue_asserts.sv
zone_queue_tb.sv

//--- zone_queue.sv
// zone_queue: top level joining the request table and the winner tree

module zone_queue #(
    parameter int num_slots = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     insert,
    input  zone_queue_pkg::zone_t    new_zone,
    input  zone_queue_pkg::prio_t    new_prio,
    input  zone_queue_pkg::wait_t    threshold,
    input  logic                     serve,
    input  logic                     cancel,
    input  zone_queue_pkg::zone_t    cancel_zone,
    output zone_queue_pkg::request_t best,
    output logic                     queue_full
);
    import zone_queue_pkg::*;

    localparam int idx_w = $clog2(num_slots);

    request_t [num_slots-1:0] slots;
    logic [idx_w-1:0]         win_index;

    // Registered slot state
    request_table #(
        .num_slots (num_slots)
    ) u_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .insert      (insert),
        .new_zone    (new_zone),
        .new_prio    (new_prio),
        .serve       (serve),
        .cancel      (cancel),
        .cancel_zone (cancel_zone),
        .threshold   (threshold),
        .win_index   (win_index),
        .slots       (slots),
        .queue_full  (queue_full)
    );

    // Combinational best-request selection
    winner_tree #(
        .num_slots (num_slots)
    ) u_tree (
        .slots     (slots),
        .best      (best),
        .win_index (win_index)
    );

endmodule

//--- zone_queue_asserts.sv
// Concurrent checks on the zone queue outputs and their bind to the top level

module zone_queue_asserts (
    input logic                     clk,
    input logic                     rst_n,
    input zone_queue_pkg::request_t best,
    input logic                     queue_full
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // A boosted winner is always a real request
    boost_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) best.boost |-> best.valid
    ) else begin
        fail_count++;
        $error("best.boost set while best.valid is low");
    end

    // A full table always presents a winner
    full_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) queue_full |-> best.valid
    ) else begin
        fail_count++;
        $error("queue_full set while best.valid is low");
    end

    // Empty right after reset release
    empty_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (!best.valid && !queue_full)
    ) else begin
        fail_count++;
        $error("queue not empty after reset release");
    end

endmodule

bind zone_queue zone_queue_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .best       (best),
    .queue_full (queue_full)
);

//--- zone_queue_pkg.sv
// Field widths, priority level enum and request entry struct for the zone queue

package zone_queue_pkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------
    localparam int zone_w = 8;
    localparam int wait_w = 8;

    // ----------------------------------------
    // Field types
    // ----------------------------------------

    // Larger value means more urgent
    typedef enum logic [1:0] {
        prio_low,
        prio_normal,
        prio_high,
        prio_urgent
    } prio_t;

    typedef logic [zone_w-1:0] zone_t;
    typedef logic [wait_w-1:0] wait_t;

    // ----------------------------------------
    // One queue slot as seen by the selector
    // ----------------------------------------
    typedef struct packed {
        logic  valid;
        logic  boost;
        zone_t zone;
        prio_t prio;
        wait_t wait_count;
    } request_t;

endpackage

//--- zone_queue_tb.sv
// Testbench for the zone queue: clock, reset, seeded random stimulus, reference model, checks

module zone_queue_tb;
    import zone_queue_pkg::*;

    logic     clk;
    logic     rst_n;
    logic     insert;
    zone_t    new_zone;
    prio_t    new_prio;
    wait_t    threshold;
    logic     serve;
    logic     cancel;
    zone_t    cancel_zone;
    request_t best;
    logic     queue_full;

    // Reference copy of the four slots
    request_t m_slot [4];
    int       errors = 0;
    int       checks = 0;

    zone_queue dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .insert      (insert),
        .new_zone    (new_zone),
        .new_prio    (new_prio),
        .threshold   (threshold),
        .serve       (serve),
        .cancel      (cancel),
        .cancel_zone (cancel_zone),
        .best        (best),
        .queue_full  (queue_full)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // Reporting helpers
    // ----------------------------------------
    task automatic report(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic timeout_error(input string what);
        errors++;
        $display("Timeout at time %0t: %s", $time, what);
    endtask

    function automatic string show(request_t r);
        return $sformatf("v=%b b=%b zone=%0d prio=%0d wait=%0d",
                         r.valid, r.boost, r.zone, r.prio, r.wait_count);
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Rank key boost, prio, wait; strict compare keeps the lower slot on a tie
    function automatic int pick_best();
        int          sel;
        logic [10:0] key;
        logic [10:0] top;
        sel = -1;
        top = '0;
        for (int i = 0; i < 4; i++) begin
            key = {m_slot[i].boost, m_slot[i].prio, m_slot[i].wait_count};
            if (m_slot[i].valid && (sel < 0 || key > top)) begin
                sel = i;
                top = key;
            end
        end
        return sel;
    endfunction

    task automatic advance_model();
        int         srv_idx;
        int         ins_idx;
        logic [3:0] clr;
        srv_idx = pick_best();
        ins_idx = -1;
        for (int i = 3; i >= 0; i--) begin
            if (!m_slot[i].valid) ins_idx = i;
        end
        for (int i = 0; i < 4; i++) begin
            clr[i] = m_slot[i].valid && ((serve && srv_idx == i) ||
                                         (cancel && m_slot[i].zone == cancel_zone));
        end
        for (int i = 0; i < 4; i++) begin
            if (clr[i]) begin
                m_slot[i].valid = 1'b0;
                m_slot[i].boost = 1'b0;
            end else if (insert && ins_idx == i) begin
                m_slot[i].valid      = 1'b1;
                m_slot[i].boost      = 1'b0;
                m_slot[i].zone       = new_zone;
                m_slot[i].prio       = new_prio;
                m_slot[i].wait_count = '0;
            end else if (m_slot[i].valid) begin
                // Boost looks at the count before this edge's increment
                if (m_slot[i].wait_count >= threshold) m_slot[i].boost = 1'b1;
                if (m_slot[i].wait_count != 8'hff) m_slot[i].wait_count++;
            end
        end
    endtask

    task automatic compare_outputs();
        int   sel;
        logic full;
        sel  = pick_best();
        full = 1'b1;
        for (int i = 0; i < 4; i++) full = full & m_slot[i].valid;
        checks++;
        if (queue_full !== full) begin
            report($sformatf("queue_full is %b, expected %b", queue_full, full));
        end
        if (sel < 0) begin
            if (best.valid !== 1'b0) report("best.valid is set on an empty queue");
        end else if (best !== m_slot[sel]) begin
            report($sformatf("best is %s, expected %s", show(best), show(m_slot[sel])));
        end
    endtask

    // ----------------------------------------
    // Stimulus, one clock cycle per call
    // ----------------------------------------
    task automatic drive_cycle(input logic ins, input zone_t z, input prio_t p,
                               input logic srv, input logic can, input zone_t cz);
        insert      = ins;
        new_zone    = z;
        new_prio    = p;
        serve       = srv;
        cancel      = can;
        cancel_zone = cz;
        @(posedge clk);
        advance_model();
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 8'd0, prio_low, 1'b0, 1'b0, 8'd0);
    endtask

    task automatic serve_cycle();
        drive_cycle(1'b0, 8'd0, prio_low, 1'b1, 1'b0, 8'd0);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (best.valid === 1'b1 && n < 16) begin
            serve_cycle();
            n++;
        end
        if (best.valid !== 1'b0) timeout_error("queue did not empty under serve");
    endtask

    task automatic check_best_zone(input zone_t z, input string what);
        if (best.valid !== 1'b1 || best.zone !== z) begin
            report($sformatf("%s: best is %s, expected zone %0d", what, show(best), z));
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int n;
        void'($urandom(32'h3ab0));
        rst_n       = 1'b0;
        insert      = 1'b0;
        new_zone    = '0;
        new_prio    = prio_low;
        threshold   = 8'd200;
        serve       = 1'b0;
        cancel      = 1'b0;
        cancel_zone = '0;
        for (int i = 0; i < 4; i++) m_slot[i] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare_outputs();

        // Empty queue, then one insert
        drive_cycle(1'b1, 8'd5, prio_high, 1'b0, 1'b0, 8'd0);
        check_best_zone(8'd5, "first insert");
        if (best.boost !== 1'b0 || best.prio !== prio_high) report("first insert fields wrong");
        drain();

        // Fill and drop
        for (int k = 0; k < 4; k++) begin
            if (queue_full !== 1'b0) report("queue_full before the fourth insert");
            drive_cycle(1'b1, zone_t'(10 + k), prio_normal, 1'b0, 1'b0, 8'd0);
        end
        if (queue_full !== 1'b1) report("queue_full low after four inserts");
        drive_cycle(1'b1, 8'd14, prio_urgent, 1'b0, 1'b0, 8'd0);
        check_best_zone(8'd10, "after dropped insert");
        for (int k = 0; k < 4; k++) begin
            if (best.valid === 1'b1 && best.zone === 8'd14) report("dropped request seen");
            serve_cycle();
        end
        if (best.valid !== 1'b0) report("queue not empty after four serves");

        // Ordering by priority, then age
        drive_cycle(1'b1, 8'd20, prio_normal, 1'b0, 1'b0, 8'd0);
        idle_cycle();
        drive_cycle(1'b1, 8'd21, prio_normal, 1'b0, 1'b0, 8'd0);
        drive_cycle(1'b1, 8'd22, prio_high, 1'b0, 1'b0, 8'd0);
        check_best_zone(8'd22, "higher priority first");
        serve_cycle();
        check_best_zone(8'd20, "oldest of equal priority");
        serve_cycle();
        check_best_zone(8'd21, "last remaining");
        drain();

        // Aging and boost
        threshold = 8'd5;
        drive_cycle(1'b1, 8'd7, prio_low, 1'b0, 1'b0, 8'd0);
        n = 0;
        while (best.boost !== 1'b1 && n < 20) begin
            idle_cycle();
            n++;
        end
        if (best.boost !== 1'b1) timeout_error("boost never appeared");
        else if (n != 6) report($sformatf("boost after %0d cycles, expected 6", n));
        drive_cycle(1'b1, 8'd8, prio_urgent, 1'b0, 1'b0, 8'd0);
        check_best_zone(8'd7, "boosted low over urgent");
        serve_cycle();
        check_best_zone(8'd8, "urgent after boosted");
        drain();

        // Saturating wait count
        threshold = 8'hff;
        drive_cycle(1'b1, 8'd40, prio_normal, 1'b0, 1'b0, 8'd0);
        n = 0;
        while (best.wait_count !== 8'hff && n < 300) begin
            idle_cycle();
            n++;
        end
        if (best.wait_count !== 8'hff) timeout_error("wait count never reached its maximum");
        repeat (5) idle_cycle();
        if (best.wait_count !== 8'hff || best.boost !== 1'b1) report("count did not hold at max");
        drain();

        // Cancel together with serve and insert
        threshold = 8'd200;
        drive_cycle(1'b1, 8'd30, prio_normal, 1'b0, 1'b0, 8'd0);
        drive_cycle(1'b1, 8'd31, prio_high, 1'b0, 1'b0, 8'd0);
        drive_cycle(1'b1, 8'd30, prio_normal, 1'b0, 1'b0, 8'd0);
        drive_cycle(1'b1, 8'd33, prio_low, 1'b1, 1'b1, 8'd30);
        check_best_zone(8'd33, "after cancel with serve");
        serve_cycle();
        if (best.valid !== 1'b0) report("queue not empty after cancel test");

        // Long random run
        for (int c = 0; c < 5000; c++) begin
            if ($urandom_range(0, 199) == 0) threshold = wait_t'($urandom_range(2, 60));
            drive_cycle($urandom_range(0, 9) < 4, zone_t'($urandom_range(1, 4)),
                        prio_t'($urandom_range(0, 3)), $urandom_range(0, 9) < 3,
                        $urandom_range(0, 19) == 0, zone_t'($urandom_range(1, 4)));
        end

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.u_asserts.fail_count);
        if (errors == 0 && dut0.u_asserts.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
